// File: src/prach_mixer_pkg.sv
`default_nettype none

package prach_mixer_pkg;

   // mixer geometry
   localparam int N_CARRIERS = 2;
   localparam int N_ANTENNAS = 2;
   // lane index is carrier * N_ANTENNAS + antenna
   localparam int N_LANES = N_CARRIERS * N_ANTENNAS;

   // width of I and of Q, a sample word is {Q, I}
   localparam int PRECISION = 16;

   // counter, coefficient and phase width
   localparam int PHASE_W = 24;

   // quarter table address taken from phase bits 21:18
   localparam int LUT_ADDR_W = 4;

   // pipeline depths in enabled cycles
   localparam int NCO_LATENCY = 4;
   localparam int MIX_LATENCY = 3;

   // wishbone word address
   localparam int WB_ADDR_W = 2;

   // round(32767 * sin(2*pi*k/64)), first quadrant only
   localparam logic signed [PRECISION-1:0] SIN_QTR [2**LUT_ADDR_W] = '{
      16'sd0,
      16'sd3212,
      16'sd6393,
      16'sd9512,
      16'sd12539,
      16'sd15446,
      16'sd18204,
      16'sd20787,
      16'sd23170,
      16'sd25329,
      16'sd27245,
      16'sd28898,
      16'sd30273,
      16'sd31356,
      16'sd32137,
      16'sd32609
   };

endpackage

`default_nettype wire

// File: src/coef_regs.sv
`timescale 1ns/1ps
`default_nettype none

module coef_regs
   import prach_mixer_pkg::*;
(
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            wb_cyc,
   input  wire                            wb_stb,
   input  wire                            wb_we,
   input  wire  [WB_ADDR_W-1:0]           wb_adr,
   input  wire  [31:0]                    wb_dat_w,
   output logic [31:0]                    wb_dat_r,
   output logic                           wb_ack,
   output logic [N_CARRIERS*PHASE_W-1:0]  coef
);

   logic [PHASE_W-1:0] coef_q [N_CARRIERS];
   logic [31:0]        rd_word;
   logic               req;

   // new request, ack not yet given
   assign req = wb_cyc && wb_stb && !wb_ack;

   // single cycle ack, held strobe gets no second ack
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= req;
      end
   end

   // unmapped addresses read as zero
   always_comb begin
      rd_word = '0;
      for (int k = 0; k < N_CARRIERS; k++) begin
         if (wb_adr == WB_ADDR_W'(k)) begin
            rd_word = 32'(coef_q[k]);
         end
      end
   end

   // read data lines up with ack
   always_ff @(posedge clk) begin
      if (req) begin
         wb_dat_r <= rd_word;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int k = 0; k < N_CARRIERS; k++) begin
            coef_q[k] <= '0;
         end
      end else if (wb_ack && wb_cyc && wb_stb && wb_we) begin
         for (int k = 0; k < N_CARRIERS; k++) begin
            if (wb_adr == WB_ADDR_W'(k)) begin
               coef_q[k] <= wb_dat_w[PHASE_W-1:0];
            end
         end
      end
   end

   genvar c;
   generate
      for (c = 0; c < N_CARRIERS; c = c + 1) begin : g_coef
         assign coef[c*PHASE_W +: PHASE_W] = coef_q[c];
      end
   endgenerate

endmodule

`default_nettype wire

// File: src/nco_bank.sv
`timescale 1ns/1ps
`default_nettype none

module nco_bank
   import prach_mixer_pkg::*;
(
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               clk_en,
   input  wire                               advance,
   input  wire  [N_CARRIERS*PHASE_W-1:0]     coef,
   output logic [N_CARRIERS*2*PRECISION-1:0] nco_cs
);

   logic [PHASE_W-1:0] cnt;

   // shared sample counter, one step per cycle with any valid lane
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (clk_en && advance) begin
         cnt <= cnt + 1'b1;
      end
   end

   genvar c;
   generate
      for (c = 0; c < N_CARRIERS; c = c + 1) begin : g_carrier
         logic [PHASE_W-1:0]            phase_r;
         logic [LUT_ADDR_W-1:0]         addr;
         logic [LUT_ADDR_W-1:0]         mirror;
         logic signed [PRECISION-1:0]   sin_lut;
         logic signed [PRECISION-1:0]   cos_lut;
         logic [1:0]                    quad_r;
         logic signed [PRECISION-1:0]   s0_r;
         logic signed [PRECISION-1:0]   c0_r;
         logic signed [PRECISION-1:0]   s1_r;
         logic signed [PRECISION-1:0]   c1_r;
         logic                          neg_s_r;
         logic                          neg_c_r;
         logic [2*PRECISION-1:0]        nco_r;

         // phase bits 21:18 address the quarter table
         assign addr   = phase_r[PHASE_W-3 -: LUT_ADDR_W];
         // cos(a) = sin(16 - a), a = 0 falls off the table
         assign mirror = LUT_ADDR_W'(0) - addr;

         assign sin_lut = SIN_QTR[addr];
         assign cos_lut = (addr == '0) ? {1'b0, {(PRECISION-1){1'b1}}} : SIN_QTR[mirror];

         // stage 1, phase is counter times coefficient mod 2^24
         always_ff @(posedge clk) begin
            if (clk_en) begin
               phase_r <= cnt * coef[c*PHASE_W +: PHASE_W];
            end
         end

         // stage 2, first quadrant lookup
         always_ff @(posedge clk) begin
            if (clk_en) begin
               quad_r <= phase_r[PHASE_W-1 -: 2];
               s0_r   <= sin_lut;
               c0_r   <= cos_lut;
            end
         end

         // stage 3, odd quadrants swap sin and cos
         always_ff @(posedge clk) begin
            if (clk_en) begin
               s1_r    <= quad_r[0] ? c0_r : s0_r;
               c1_r    <= quad_r[0] ? s0_r : c0_r;
               neg_s_r <= quad_r[1];
               neg_c_r <= quad_r[1] ^ quad_r[0];
            end
         end

         // stage 4, quadrant sign and {sin, cos} packing
         always_ff @(posedge clk) begin
            if (clk_en) begin
               nco_r <= {neg_s_r ? -s1_r : s1_r, neg_c_r ? -c1_r : c1_r};
            end
         end

         assign nco_cs[c*2*PRECISION +: 2*PRECISION] = nco_r;
      end
   endgenerate

endmodule

`default_nettype wire

// File: src/lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module lane_align
   import prach_mixer_pkg::*;
(
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        clk_en,
   input  wire                        valid_in,
   input  wire  [2*PRECISION-1:0]     data_in,
   output logic                       valid_out,
   output logic [2*PRECISION-1:0]     data_out
);

   logic [NCO_LATENCY-1:0] valid_sr;
   logic [2*PRECISION-1:0] data_sr [NCO_LATENCY];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_sr <= '0;
      end else if (clk_en) begin
         valid_sr <= {valid_sr[NCO_LATENCY-2:0], valid_in};
      end
   end

   // one sample per stage, matches nco pipeline
   always_ff @(posedge clk) begin
      if (clk_en) begin
         data_sr[0] <= data_in;
         for (int i = 1; i < NCO_LATENCY; i++) begin
            data_sr[i] <= data_sr[i-1];
         end
      end
   end

   assign valid_out = valid_sr[NCO_LATENCY-1];
   assign data_out  = data_sr[NCO_LATENCY-1];

endmodule

`default_nettype wire

// File: src/cmplx_mix.sv
`timescale 1ns/1ps
`default_nettype none

module cmplx_mix
   import prach_mixer_pkg::*;
(
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        clk_en,
   input  wire                        valid_in,
   input  wire  [2*PRECISION-1:0]     data_in,
   input  wire  [2*PRECISION-1:0]     nco,
   output logic                       valid_out,
   output logic [2*PRECISION-1:0]     data_out
);

   logic signed [PRECISION-1:0]   ai;
   logic signed [PRECISION-1:0]   aq;
   logic signed [PRECISION-1:0]   nc;
   logic signed [PRECISION-1:0]   ns;
   logic signed [2*PRECISION-1:0] p_ic;
   logic signed [2*PRECISION-1:0] p_qs;
   logic signed [2*PRECISION-1:0] p_is;
   logic signed [2*PRECISION-1:0] p_qc;
   logic signed [2*PRECISION-1:0] sum_i;
   logic signed [2*PRECISION-1:0] sum_q;
   logic [2*PRECISION-1:0]        dout_r;
   logic [MIX_LATENCY-1:0]        valid_sr;

   // sample is {Q, I}, nco is {sin, cos}
   assign ai = data_in[PRECISION-1:0];
   assign aq = data_in[2*PRECISION-1:PRECISION];
   assign nc = nco[PRECISION-1:0];
   assign ns = nco[2*PRECISION-1:PRECISION];

   always_ff @(posedge clk) begin
      if (clk_en) begin
         p_ic <= ai * nc;
         p_qs <= aq * ns;
         p_is <= ai * ns;
         p_qc <= aq * nc;
      end
   end

   // nco magnitude stays below 2^15, sums fit 32 bits
   always_ff @(posedge clk) begin
      if (clk_en) begin
         sum_i <= p_ic - p_qs;
         sum_q <= p_is + p_qc;
      end
   end

   // keep bits 30:15, plain truncation
   always_ff @(posedge clk) begin
      if (clk_en) begin
         dout_r <= {sum_q[2*PRECISION-2 -: PRECISION], sum_i[2*PRECISION-2 -: PRECISION]};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_sr <= '0;
      end else if (clk_en) begin
         valid_sr <= {valid_sr[MIX_LATENCY-2:0], valid_in};
      end
   end

   assign valid_out = valid_sr[MIX_LATENCY-1];
   assign data_out  = dout_r;

endmodule

`default_nettype wire

// File: src/prach_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module prach_mixer
   import prach_mixer_pkg::*;
(
   input  wire                              clk,
   input  wire                              rst_n,
   input  wire                              clk_en,
   input  wire                              wb_cyc,
   input  wire                              wb_stb,
   input  wire                              wb_we,
   input  wire  [WB_ADDR_W-1:0]             wb_adr,
   input  wire  [31:0]                      wb_dat_w,
   output wire  [31:0]                      wb_dat_r,
   output wire                              wb_ack,
   input  wire  [N_LANES-1:0]               tvalid_in,
   input  wire  [N_LANES*2*PRECISION-1:0]   tdata_in,
   output wire  [N_LANES-1:0]               tvalid_out,
   output wire  [N_LANES*2*PRECISION-1:0]   tdata_out
);

   logic [N_CARRIERS*PHASE_W-1:0]     coef;
   logic [N_CARRIERS*2*PRECISION-1:0] nco_cs;
   logic                              sample_seen;
   logic [N_LANES-1:0]                al_valid;
   logic [N_LANES*2*PRECISION-1:0]    al_data;

   // counter steps once per cycle with a valid sample on any lane
   assign sample_seen = |tvalid_in;

   coef_regs u_coef_regs (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .coef     (coef)
   );

   nco_bank u_nco_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .clk_en  (clk_en),
      .advance (sample_seen),
      .coef    (coef),
      .nco_cs  (nco_cs)
   );

   genvar l;
   generate
      for (l = 0; l < N_LANES; l = l + 1) begin : g_lane
         lane_align u_lane_align (
            .clk       (clk),
            .rst_n     (rst_n),
            .clk_en    (clk_en),
            .valid_in  (tvalid_in[l]),
            .data_in   (tdata_in[l*2*PRECISION +: 2*PRECISION]),
            .valid_out (al_valid[l]),
            .data_out  (al_data[l*2*PRECISION +: 2*PRECISION])
         );

         // every antenna of a carrier shares that carrier's nco
         cmplx_mix u_cmplx_mix (
            .clk       (clk),
            .rst_n     (rst_n),
            .clk_en    (clk_en),
            .valid_in  (al_valid[l]),
            .data_in   (al_data[l*2*PRECISION +: 2*PRECISION]),
            .nco       (nco_cs[(l / N_ANTENNAS)*2*PRECISION +: 2*PRECISION]),
            .valid_out (tvalid_out[l]),
            .data_out  (tdata_out[l*2*PRECISION +: 2*PRECISION])
         );
      end
   endgenerate

endmodule

`default_nettype wire

// File: test/tb_prach_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_prach_mixer
   import prach_mixer_pkg::*;
();

   localparam int PIPE_DELAY    = 7;
   localparam int ACK_TIMEOUT   = 20;
   localparam int DRAIN_TIMEOUT = 200;

   logic                           clk;
   logic                           rst_n;
   logic                           clk_en;
   logic                           wb_cyc;
   logic                           wb_stb;
   logic                           wb_we;
   logic [WB_ADDR_W-1:0]           wb_adr;
   logic [31:0]                    wb_dat_w;
   wire  [31:0]                    wb_dat_r;
   wire                            wb_ack;
   logic [N_LANES-1:0]             tvalid_in;
   logic [N_LANES*2*PRECISION-1:0] tdata_in;
   wire  [N_LANES-1:0]             tvalid_out;
   wire  [N_LANES*2*PRECISION-1:0] tdata_out;

   // expected words from the data file, observed beats and enabled-cycle stamps
   logic [31:0] exp_q     [N_LANES][$];
   logic [31:0] got_q     [N_LANES][$];
   int          in_stamp  [N_LANES][$];
   int          out_stamp [N_LANES][$];
   int          ecnt;
   int          errors;
   integer      seed;

   prach_mixer DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .clk_en     (clk_en),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .tvalid_in  (tvalid_in),
      .tdata_in   (tdata_in),
      .tvalid_out (tvalid_out),
      .tdata_out  (tdata_out)
   );

   always #2 clk = ~clk;

   // beats count only on enabled cycles, sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n && clk_en) begin
         for (int l = 0; l < N_LANES; l++) begin
            if (tvalid_in[l]) begin
               in_stamp[l].push_back(ecnt);
            end
            if (tvalid_out[l]) begin
               got_q[l].push_back(tdata_out[l*32 +: 32]);
               out_stamp[l].push_back(ecnt);
            end
         end
         ecnt++;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic match_outputs();
      for (int l = 0; l < N_LANES; l++) begin
         while (got_q[l].size() > 0 && exp_q[l].size() > 0) begin
            check_value($sformatf("tdata_out[%0d]", l), got_q[l].pop_front(),
                        exp_q[l].pop_front());
         end
         while (out_stamp[l].size() > 0 && in_stamp[l].size() > 0) begin
            check_value($sformatf("tvalid_out[%0d] latency", l),
                        out_stamp[l].pop_front() - in_stamp[l].pop_front(), PIPE_DELAY);
         end
      end
   endtask

   function automatic bit expected_left();
      bit left;
      left = 1'b0;
      for (int l = 0; l < N_LANES; l++) begin
         if (exp_q[l].size() > 0) begin
            left = 1'b1;
         end
      end
      return left;
   endfunction

   task automatic drive_cycle(input logic en, input logic [N_LANES-1:0] mask,
                              input logic [N_LANES*2*PRECISION-1:0] data);
      clk_en    = en;
      tvalid_in = mask;
      tdata_in  = data;
      @(posedge clk);
      #1;
      clk_en    = 1'b1;
      tvalid_in = '0;
   endtask

   // classic cycle, held until ack, then one idle cycle must show ack low
   task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                            input logic [31:0] wdat, input logic [31:0] rexp);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      @(negedge clk);
      while (!wb_ack && waited < ACK_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!wb_ack) begin
         $display("timeout waiting for wishbone ack at address %0d", adr);
         errors++;
      end else if (!we) begin
         check_value("wb_dat_r", wb_dat_r, rexp);
      end
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge clk);
      check_value("wb_ack", 32'(wb_ack), 32'h0);
      @(posedge clk);
      #1;
   endtask

   initial begin
      int                 fd;
      int                 code;
      int                 need;
      int                 gap;
      int                 waited;
      logic [7:0]         kind;
      logic [WB_ADDR_W-1:0] adr;
      logic [31:0]        word;
      logic [31:0]        d [N_LANES];
      logic               en;
      logic [N_LANES-1:0] mask;
      logic [1:0]         lane;
      logic [8*128-1:0]   line;

      clk       = 1'b0;
      rst_n     = 1'b0;
      clk_en    = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      tvalid_in = '0;
      tdata_in  = '0;
      errors    = 0;
      ecnt      = 0;
      seed      = 32'h140a;
      repeat (16) @(posedge clk);
      #1;
      rst_n  = 1'b1;
      clk_en = 1'b1;
      @(posedge clk);
      #1;

      fd = $fopen("test/mixer_input.txt", "r");
      if (fd == 0) begin
         $display("could not open test/mixer_input.txt");
         errors++;
      end else begin
         while ($fscanf(fd, " %c", kind) == 1) begin
            need = 0;
            case (kind)
               "W": begin
                  need = 2;
                  code = $fscanf(fd, "%h %h", adr, word);
                  wb_access(1'b1, adr, word, 32'h0);
               end
               "R": begin
                  need = 2;
                  code = $fscanf(fd, "%h %h", adr, word);
                  wb_access(1'b0, adr, 32'h0, word);
               end
               "S": begin
                  need = 6;
                  code = $fscanf(fd, "%h %h %h %h %h %h", en, mask, d[0], d[1], d[2], d[3]);
                  // idle gaps hold the counter, results stay the same
                  gap = {$random(seed)} % 3;
                  repeat (gap) drive_cycle(1'b1, '0, tdata_in);
                  drive_cycle(en, mask, {d[3], d[2], d[1], d[0]});
               end
               "E": begin
                  need = 2;
                  code = $fscanf(fd, "%h %h", lane, word);
                  exp_q[lane].push_back(word);
               end
               "#": begin
                  code = $fgets(line, fd);
               end
               default: begin
                  $display("unknown record type in the data file");
                  errors++;
                  code = $fgets(line, fd);
               end
            endcase
            if (need != 0 && code != need) begin
               $display("malformed %c record in the data file", kind);
               errors++;
            end
            match_outputs();
         end
         $fclose(fd);
      end

      waited = 0;
      while (expected_left() && waited < DRAIN_TIMEOUT) begin
         @(posedge clk);
         #1;
         match_outputs();
         waited++;
      end
      if (expected_left()) begin
         $display("timeout waiting for expected output beats");
         errors++;
      end
      repeat (2*PIPE_DELAY) @(posedge clk);
      match_outputs();
      for (int l = 0; l < N_LANES; l++) begin
         if (got_q[l].size() != 0) begin
            $display("unexpected output beats on lane %0d", l);
            errors++;
         end
      end

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: test/mixer_input.txt
# W adr data, R adr expected data, E lane expected word
# S clk_en mask lane0 lane1 lane2 lane3, all hex, sample word is Q over I
W 0 ABCDEF12
W 1 FF123456
W 2 DEADBEEF
R 0 00CDEF12
R 1 00123456
R 2 00000000
R 3 00000000
W 0 00000000
W 1 00000000
S 1 F FF001234 7FFF8001 00000000 40000001
E 0 FF001233
E 1 7FFE8001
E 2 00000000
E 3 3FFF0000
W 0 00040000
W 1 00100000
R 0 00040000
S 1 F 00004000 00004000 00004000 00004000
S 1 F 00004000 00004000 00004000 00004000
S 1 0 00000000 00000000 00000000 00000000
S 1 F 00004000 00004000 00004000 00004000
S 0 F DEADBEEF DEADBEEF DEADBEEF DEADBEEF
S 0 0 00000000 00000000 00000000 00000000
S 1 F 00004000 00004000 00004000 00004000
S 1 5 40000000 DEADBEEF 40000000 DEADBEEF
S 1 2 00000000 00004000 00000000 00000000
E 0 06463FB0
E 1 06463FB0
E 2 187D3B20
E 3 187D3B20
E 0 0C7C3EC4
E 1 0C7C3EC4
E 2 2D412D41
E 3 2D412D41
E 0 12943D3E
E 1 12943D3E
E 2 3B20187D
E 3 3B20187D
E 0 187D3B20
E 1 187D3B20
E 2 3FFF0000
E 3 3FFF0000
E 0 3871E1D5
E 2 E782C4DF
E 1 238E3536

// File: verilog.f
src/prach_mixer_pkg.sv
src/coef_regs.sv
src/nco_bank.sv
src/lane_align.sv
src/cmplx_mix.sv
src/prach_mixer.sv
test/tb_prach_mixer.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
TOP       := tb_prach_mixer
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
